// File: alu_top.f
hw/alu_pkg.sv
hw/alu_operand_stage.sv
hw/alu_arith_unit.sv
hw/alu_logic_unit.sv
hw/alu_result_merge.sv
hw/alu_top.sv
bench/alu_tb_clock.sv
bench/alu_properties.sv
bench/alu_tb.sv

// File: bench/alu_properties.sv
`timescale 1ns/1ns

module alu_properties #(
  parameter int OPERAND_WIDTH = 8
) (
  input logic                          CLK,
  input logic                          RST,
  input logic                          ce,
  input logic                          mode,
  input logic [alu_pkg::CMD_WIDTH-1:0] cmd,
  input logic [1:0]                    inp_valid,
  input logic [2*OPERAND_WIDTH-1:0]    res,
  input logic                          cout,
  input logic                          oflow,
  input logic                          e,
  input logic                          g,
  input logic                          l,
  input logic                          err
);

  int   fail_count = 0;  // Failed assertion count
  logic rotate_op;       // Rotate presented this cycle
  logic flags_clear;

  assign rotate_op   = ce && !mode && (inp_valid == alu_pkg::VALID_BOTH) &&
                       (cmd == alu_pkg::LOGIC_ROL || cmd == alu_pkg::LOGIC_ROR);
  assign flags_clear = !(cout || oflow || e || g || l);

  compare_onehot: assert property (@(posedge CLK) disable iff (RST) $onehot0({e, g, l}))
    else begin
      $error("more than one of e, g and l is set");
      fail_count++;
    end

  err_flags_clear: assert property (@(posedge CLK) disable iff (RST) err |-> flags_clear)
    else begin
      $error("err is set together with another flag");
      fail_count++;
    end

  // Out of range rotate keeps its result two edges later
  err_result_zero: assert property (@(posedge CLK) disable iff (RST)
    err |-> (res == '0) || $past(rotate_op, 2))
    else begin
      $error("err is set with a nonzero result");
      fail_count++;
    end

  idle_slot_zero: assert property (@(posedge CLK) disable iff (RST)
    !$past(ce, 2) |-> (res == '0) && flags_clear && !err)
    else begin
      $error("outputs not zero after an operation with ce low");
      fail_count++;
    end

endmodule

// File: bench/alu_tb.sv
`timescale 1ns/1ns

module alu_tb;

  localparam int W           = 8;
  localparam int RST_CYCLES  = 16;
  localparam int DRIVE_DELAY = 2;
  localparam int N_RAND      = 8;
  // Reset, arith, compare, logic, validity, ce low, mix, then two flush cycles per test
  localparam int TEST_CYCLES = RST_CYCLES + 3 + 8 * (4 + N_RAND) + 3 * (4 + N_RAND)
                               + 14 * N_RAND + 8 + 2 * 16 * 4 + 2 * N_RAND + 64 + 7 * 2;
  localparam int CYCLE_LIMIT = TEST_CYCLES + 50;

  typedef struct packed {
    logic           ce;
    logic           mode;
    logic [3:0]     cmd;
    logic [1:0]     valid;
    logic           cin;
    logic [W-1:0]   a;
    logic [W-1:0]   b;
  } alu_op_t;

  typedef struct packed {
    logic [2*W-1:0]      res;
    alu_pkg::alu_flags_t flags;
  } alu_out_t;

  logic           CLK;
  logic           RST;
  alu_op_t        op;
  logic [2*W-1:0] res;
  logic           cout;
  logic           oflow;
  logic           e;
  logic           g;
  logic           l;
  logic           err;
  alu_out_t       exp_q1 = '0;  // Model pipeline matching DUT latency
  alu_out_t       exp_q2 = '0;
  integer         seed   = 32'h2737_df0a;
  int             errors = 0;
  int             checks = 0;
  int             tests  = 0;
  int             cycles = 0;
  int             test_errors = 0;
  logic [3:0]     cmp_cmds [3] = '{alu_pkg::ARITH_CMP, alu_pkg::ARITH_SADD, alu_pkg::ARITH_SSUB};
  logic [W-1:0]   fixed_a  [4] = '{8'h5a, 8'h80, 8'h01, 8'h80};  // Equal, sign differing
  logic [W-1:0]   fixed_b  [4] = '{8'h5a, 8'h01, 8'h80, 8'h80};

  alu_tb_clock #(.PERIOD(40), .RST_CYCLES(RST_CYCLES)) clock_i (.CLK(CLK), .RST(RST));

  alu_top #(.OPERAND_WIDTH(W)) dut_i (
    .CLK(CLK), .RST(RST), .ce(op.ce), .mode(op.mode), .cin(op.cin), .cmd(op.cmd),
    .inp_valid(op.valid), .opa(op.a), .opb(op.b),
    .res(res), .cout(cout), .oflow(oflow), .e(e), .g(g), .l(l), .err(err)
  );

  bind alu_top alu_properties #(.OPERAND_WIDTH(OPERAND_WIDTH)) props_i (
    .CLK(CLK), .RST(RST), .ce(ce), .mode(mode), .cmd(cmd), .inp_valid(inp_valid),
    .res(res), .cout(cout), .oflow(oflow), .e(e), .g(g), .l(l), .err(err)
  );

  function automatic int to_signed(input logic [W-1:0] v);
    return v[W-1] ? int'(v) - (1 << W) : int'(v);
  endfunction

  // Expected outputs from the ALU rules
  function automatic alu_out_t model_out(input alu_op_t o);
    alu_out_t r;
    int       a;
    int       b;
    int       x;
    int       k;
    int       mask;
    logic     ok;
    logic     sgn;
    r    = '0;
    a    = o.a;
    b    = o.b;
    x    = 0;
    mask = (1 << W) - 1;
    sgn  = o.mode && (o.cmd inside {alu_pkg::ARITH_SADD, alu_pkg::ARITH_SSUB});
    if (!o.ce) return r;  // Idle slot
    if (o.mode) begin
      ok = (o.valid == 2'd1) ? o.cmd inside {alu_pkg::ARITH_INC_A, alu_pkg::ARITH_DEC_A} :
           (o.valid == 2'd2) ? o.cmd inside {alu_pkg::ARITH_INC_B, alu_pkg::ARITH_DEC_B} :
           (o.valid == 2'd3) && (o.cmd <= alu_pkg::ARITH_CMP || sgn);
    end else begin
      ok = (o.valid == 2'd1) ? o.cmd inside {alu_pkg::LOGIC_NOT_A, alu_pkg::LOGIC_SHR_A,
                                             alu_pkg::LOGIC_SHL_A} :
           (o.valid == 2'd2) ? o.cmd inside {alu_pkg::LOGIC_NOT_B, alu_pkg::LOGIC_SHR_B,
                                             alu_pkg::LOGIC_SHL_B} :
           (o.valid == 2'd3) && (o.cmd <= alu_pkg::LOGIC_ROR);
    end
    if (!ok) begin
      r.flags.err = 1'b1;
      return r;
    end
    if (o.mode) begin
      if (sgn) begin
        a = to_signed(o.a);
        b = to_signed(o.b);
      end
      case (o.cmd)
        alu_pkg::ARITH_ADD, alu_pkg::ARITH_SADD: x = a + b;
        alu_pkg::ARITH_SUB, alu_pkg::ARITH_SSUB: x = a - b;
        alu_pkg::ARITH_ADD_CIN: x = a + b + o.cin;
        alu_pkg::ARITH_SUB_CIN: x = a - b - o.cin;
        alu_pkg::ARITH_INC_A:   x = a + 1;
        alu_pkg::ARITH_DEC_A:   x = a - 1;
        alu_pkg::ARITH_INC_B:   x = b + 1;
        alu_pkg::ARITH_DEC_B:   x = b - 1;
        default:                x = 0;  // Compare has no result
      endcase
      r.res = (2*W)'(x & ((1 << (W + 1)) - 1));  // W+1 bit wrap
      r.flags.cout  = (o.cmd inside {alu_pkg::ARITH_ADD, alu_pkg::ARITH_ADD_CIN,
                       alu_pkg::ARITH_INC_A, alu_pkg::ARITH_INC_B}) ? (x > mask) :
                      (o.cmd == alu_pkg::ARITH_SADD) && (x < 0);  // Sign of the wide sum
      r.flags.oflow = (o.cmd inside {alu_pkg::ARITH_SUB, alu_pkg::ARITH_SUB_CIN,
                       alu_pkg::ARITH_DEC_A, alu_pkg::ARITH_DEC_B}) ? (x < 0) :
                      sgn && (x >= (1 << (W - 1)) || x < -(1 << (W - 1)));
      if (sgn || o.cmd == alu_pkg::ARITH_CMP) begin
        r.flags.e = (a == b);
        r.flags.g = (a > b);
        r.flags.l = (a < b);
      end
    end else begin
      case (o.cmd)
        alu_pkg::LOGIC_AND:   x = a & b;
        alu_pkg::LOGIC_NAND:  x = ~(a & b);
        alu_pkg::LOGIC_OR:    x = a | b;
        alu_pkg::LOGIC_NOR:   x = ~(a | b);
        alu_pkg::LOGIC_XOR:   x = a ^ b;
        alu_pkg::LOGIC_XNOR:  x = ~(a ^ b);
        alu_pkg::LOGIC_NOT_A: x = ~a;
        alu_pkg::LOGIC_NOT_B: x = ~b;
        alu_pkg::LOGIC_SHR_A: x = a >> 1;
        alu_pkg::LOGIC_SHL_A: x = a << 1;
        alu_pkg::LOGIC_SHR_B: x = b >> 1;
        alu_pkg::LOGIC_SHL_B: x = b << 1;
        default: begin  // Rotate one bit per step
          x = a;
          for (k = 0; k < b % W; k++) begin
            x = (o.cmd == alu_pkg::LOGIC_ROL) ? ((x << 1) | (x >> (W - 1))) & mask :
                                                (x >> 1) | ((x & 1) << (W - 1));
          end
          r.flags.err = (b >= W);
        end
      endcase
      r.res = (2*W)'(x & mask);
    end
    return r;
  endfunction

  function automatic logic [W-1:0] rand_byte();
    return W'($random(seed));
  endfunction

  task automatic drive_op(input logic op_ce, input logic op_mode, input logic [3:0] op_cmd,
                          input logic [1:0] op_valid, input logic op_cin,
                          input logic [W-1:0] op_a, input logic [W-1:0] op_b);
    @(posedge CLK);
    #DRIVE_DELAY;
    op = '{op_ce, op_mode, op_cmd, op_valid, op_cin, op_a, op_b};
  endtask

  task automatic check_field(input string name, input logic [2*W-1:0] expv,
                             input logic [2*W-1:0] gotv);
    checks++;
    assert (gotv === expv) else begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expv, gotv);
    end
  endtask

  // Two idle slots drain the pipeline before the count
  task automatic end_test(input string name);
    drive_op(1'b0, 1'b0, 4'd0, 2'd0, 1'b0, '0, '0);
    drive_op(1'b0, 1'b0, 4'd0, 2'd0, 1'b0, '0, '0);
    @(negedge CLK);
    #1;
    tests++;
    $display("test %s done, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  always @(posedge CLK) begin
    exp_q1 <= model_out(op);  // Inputs are stable at the edge
    exp_q2 <= exp_q1;
  end

  always @(negedge CLK) begin
    if (!RST) begin  // From reset release on
      check_field("res", exp_q2.res, res);
      check_field("cout", 16'(exp_q2.flags.cout), 16'(cout));
      check_field("oflow", 16'(exp_q2.flags.oflow), 16'(oflow));
      check_field("e", 16'(exp_q2.flags.e), 16'(e));
      check_field("g", 16'(exp_q2.flags.g), 16'(g));
      check_field("l", 16'(exp_q2.flags.l), 16'(l));
      check_field("err", 16'(exp_q2.flags.err), 16'(err));
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    int i;
    int c;
    int v;
    int m;
    op = '0;
    @(posedge CLK);
    while (RST) @(posedge CLK);
    end_test("reset");
    for (c = 0; c <= 7; c++) begin  // Unsigned add, subtract, inc, dec
      drive_op(1'b1, 1'b1, 4'(c), 2'd3, 1'b0, 8'h00, 8'h00);
      drive_op(1'b1, 1'b1, 4'(c), 2'd3, 1'b1, 8'hff, 8'hff);
      drive_op(1'b1, 1'b1, 4'(c), 2'd3, 1'b1, 8'h00, 8'hff);
      drive_op(1'b1, 1'b1, 4'(c), 2'd3, 1'b0, 8'hff, 8'h00);
      repeat (N_RAND) drive_op(1'b1, 1'b1, 4'(c), 2'd3, rand_byte() > 8'd127, rand_byte(),
                               rand_byte());
    end
    end_test("arith");
    for (i = 0; i < 3; i++) begin
      for (c = 0; c < 4; c++) begin
        drive_op(1'b1, 1'b1, cmp_cmds[i], 2'd3, 1'b0, fixed_a[c], fixed_b[c]);
      end
      repeat (N_RAND) drive_op(1'b1, 1'b1, cmp_cmds[i], 2'd3, 1'b0, rand_byte(), rand_byte());
    end
    end_test("compare");
    for (c = 0; c <= 13; c++) begin
      repeat (N_RAND) drive_op(1'b1, 1'b0, 4'(c), 2'd3, 1'b0, rand_byte(), rand_byte());
    end
    for (i = 0; i < 4; i++) begin  // Rotate amount out of range
      drive_op(1'b1, 1'b0, alu_pkg::LOGIC_ROL, 2'd3, 1'b0, rand_byte(), rand_byte() | 8'h10);
      drive_op(1'b1, 1'b0, alu_pkg::LOGIC_ROR, 2'd3, 1'b0, rand_byte(), rand_byte() | 8'h08);
    end
    end_test("logic");
    for (m = 0; m < 2; m++) begin  // Every mode, command and valid code
      for (c = 0; c < 16; c++) begin
        for (v = 0; v < 4; v++) begin
          drive_op(1'b1, m[0], 4'(c), 2'(v), rand_byte() > 8'd127, rand_byte(), rand_byte());
        end
      end
    end
    end_test("validity");
    repeat (2 * N_RAND) drive_op(1'b0, rand_byte() > 8'd127, 4'(rand_byte()), 2'd3, 1'b1,
                                 rand_byte(), rand_byte());
    end_test("ce_low");
    repeat (64) drive_op(rand_byte() > 8'd31, rand_byte() > 8'd127, 4'(rand_byte()),
                         2'(rand_byte()), rand_byte() > 8'd127, rand_byte(), rand_byte());
    end_test("pipeline");
    errors += dut_i.props_i.fail_count;  // Bound assertion failures
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: bench/alu_tb_clock.sv
`timescale 1ns/1ns

module alu_tb_clock #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 16,
  parameter int RST_DELAY  = 2
) (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;  // First rising edge at half period
  end

  initial begin
    RST = 1'b1;  // Held from time zero
    repeat (RST_CYCLES) @(posedge CLK);
    #RST_DELAY;
    RST = 1'b0;  // Released just after an edge
  end

endmodule

// File: hw/alu_arith_unit.sv
`timescale 1ns/1ns

module alu_arith_unit #(
  parameter int OPERAND_WIDTH = 8
) (
  input  logic [OPERAND_WIDTH-1:0]   op_a,
  input  logic [OPERAND_WIDTH-1:0]   op_b,
  input  alu_pkg::alu_ctrl_t         ctrl,
  output logic [2*OPERAND_WIDTH-1:0] result,
  output alu_pkg::alu_flags_t        flags
);

  localparam int W = OPERAND_WIDTH;

  logic [W:0] ext_a;   // Zero extended operands
  logic [W:0] ext_b;
  logic [W:0] sum;
  logic [W:0] sum_c;
  logic [W:0] diff;
  logic [W:0] diff_c;
  logic [W:0] inc_a;
  logic [W:0] dec_a;
  logic [W:0] inc_b;
  logic [W:0] dec_b;
  logic [W:0] ssum;    // Sign extended sum
  logic [W:0] sdiff;   // Sign extended difference
  logic       a_msb;
  logic       b_msb;
  logic       eq;
  logic       ugt;
  logic       sgt;
  logic       legal;
  logic [W:0] res_n;

  assign ext_a  = {1'b0, op_a};
  assign ext_b  = {1'b0, op_b};
  assign sum    = ext_a + ext_b;
  assign sum_c  = ext_a + ext_b + ctrl.cin;
  assign diff   = ext_a - ext_b;              // Wraps modulo 2^(W+1)
  assign diff_c = ext_a - ext_b - ctrl.cin;
  assign inc_a  = ext_a + 1'b1;
  assign dec_a  = ext_a - 1'b1;
  assign inc_b  = ext_b + 1'b1;
  assign dec_b  = ext_b - 1'b1;

  assign a_msb = op_a[W-1];
  assign b_msb = op_b[W-1];
  assign ssum  = {a_msb, op_a} + {b_msb, op_b};
  assign sdiff = {a_msb, op_a} - {b_msb, op_b};

  assign eq  = (op_a == op_b);
  assign ugt = (op_a > op_b);
  assign sgt = ($signed(op_a) > $signed(op_b));

  // Command legality against operand valid code
  always_comb begin
    case (ctrl.valid)
      alu_pkg::VALID_A:
        legal = (ctrl.cmd == alu_pkg::ARITH_INC_A) || (ctrl.cmd == alu_pkg::ARITH_DEC_A);
      alu_pkg::VALID_B:
        legal = (ctrl.cmd == alu_pkg::ARITH_INC_B) || (ctrl.cmd == alu_pkg::ARITH_DEC_B);
      alu_pkg::VALID_BOTH:
        legal = (ctrl.cmd <= alu_pkg::ARITH_CMP) ||
                (ctrl.cmd == alu_pkg::ARITH_SADD) || (ctrl.cmd == alu_pkg::ARITH_SSUB);
      default:
        legal = 1'b0;  // No operand valid
    endcase
  end

  always_comb begin
    res_n = '0;
    flags = '0;
    if (!legal) begin
      flags.err = 1'b1;  // Zero result, other flags clear
    end else begin
      case (ctrl.cmd)
        alu_pkg::ARITH_ADD: begin
          res_n      = sum;
          flags.cout = sum[W];
        end
        alu_pkg::ARITH_SUB: begin
          res_n       = diff;
          flags.oflow = (op_a < op_b);  // Borrow out
        end
        alu_pkg::ARITH_ADD_CIN: begin
          res_n      = sum_c;
          flags.cout = sum_c[W];
        end
        alu_pkg::ARITH_SUB_CIN: begin
          res_n       = diff_c;
          flags.oflow = (op_a < op_b) || (eq && ctrl.cin);
        end
        alu_pkg::ARITH_INC_A: begin
          res_n      = inc_a;
          flags.cout = inc_a[W];
        end
        alu_pkg::ARITH_DEC_A: begin
          res_n       = dec_a;
          flags.oflow = (op_a == '0);
        end
        alu_pkg::ARITH_INC_B: begin
          res_n      = inc_b;
          flags.cout = inc_b[W];
        end
        alu_pkg::ARITH_DEC_B: begin
          res_n       = dec_b;
          flags.oflow = (op_b == '0);
        end
        alu_pkg::ARITH_CMP: begin
          flags.e = eq;  // Unsigned, result stays zero
          flags.g = ugt;
          flags.l = !eq && !ugt;
        end
        alu_pkg::ARITH_SADD: begin
          res_n       = ssum;
          flags.cout  = ssum[W];
          flags.oflow = (a_msb & b_msb & ~ssum[W-1]) | (~a_msb & ~b_msb & ssum[W-1]);
          flags.e     = eq;
          flags.g     = sgt;
          flags.l     = !eq && !sgt;
        end
        default: begin  // ARITH_SSUB, the only legal code left
          res_n       = sdiff;
          flags.oflow = (~a_msb & b_msb & sdiff[W-1]) | (a_msb & ~b_msb & ~sdiff[W-1]);
          flags.e     = eq;
          flags.g     = sgt;
          flags.l     = !eq && !sgt;
        end
      endcase
    end
  end

  assign result = {{(W-1){1'b0}}, res_n};  // Upper bits always zero

endmodule

// File: hw/alu_logic_unit.sv
`timescale 1ns/1ns

module alu_logic_unit #(
  parameter int OPERAND_WIDTH = 8
) (
  input  logic [OPERAND_WIDTH-1:0]   op_a,
  input  logic [OPERAND_WIDTH-1:0]   op_b,
  input  alu_pkg::alu_ctrl_t         ctrl,
  output logic [2*OPERAND_WIDTH-1:0] result,
  output alu_pkg::alu_flags_t        flags
);

  localparam int W  = OPERAND_WIDTH;
  localparam int SH = $clog2(OPERAND_WIDTH);  // Rotate amount bits

  logic [SH-1:0] amt;
  logic          amt_oor;   // Rotate amount out of range
  logic [W-1:0]  rol;
  logic [W-1:0]  ror;
  logic          legal;
  logic [W-1:0]  res_n;

  assign amt     = op_b[SH-1:0];
  assign amt_oor = |op_b[W-1:SH];
  assign rol     = (op_a << amt) | (op_a >> (W - amt));  // amt 0 leaves op_a
  assign ror     = (op_a >> amt) | (op_a << (W - amt));

  always_comb begin
    case (ctrl.valid)
      alu_pkg::VALID_A:
        legal = (ctrl.cmd == alu_pkg::LOGIC_NOT_A) || (ctrl.cmd == alu_pkg::LOGIC_SHR_A) ||
                (ctrl.cmd == alu_pkg::LOGIC_SHL_A);
      alu_pkg::VALID_B:
        legal = (ctrl.cmd == alu_pkg::LOGIC_NOT_B) || (ctrl.cmd == alu_pkg::LOGIC_SHR_B) ||
                (ctrl.cmd == alu_pkg::LOGIC_SHL_B);
      alu_pkg::VALID_BOTH:
        legal = (ctrl.cmd <= alu_pkg::LOGIC_ROR);  // 14 and 15 unused
      default:
        legal = 1'b0;
    endcase
  end

  always_comb begin
    res_n = '0;
    flags = '0;
    if (!legal) begin
      flags.err = 1'b1;
    end else begin
      case (ctrl.cmd)
        alu_pkg::LOGIC_AND:   res_n = op_a & op_b;
        alu_pkg::LOGIC_NAND:  res_n = ~(op_a & op_b);
        alu_pkg::LOGIC_OR:    res_n = op_a | op_b;
        alu_pkg::LOGIC_NOR:   res_n = ~(op_a | op_b);
        alu_pkg::LOGIC_XOR:   res_n = op_a ^ op_b;
        alu_pkg::LOGIC_XNOR:  res_n = ~(op_a ^ op_b);
        alu_pkg::LOGIC_NOT_A: res_n = ~op_a;
        alu_pkg::LOGIC_NOT_B: res_n = ~op_b;
        alu_pkg::LOGIC_SHR_A: res_n = op_a >> 1;
        alu_pkg::LOGIC_SHL_A: res_n = op_a << 1;  // MSB dropped
        alu_pkg::LOGIC_SHR_B: res_n = op_b >> 1;
        alu_pkg::LOGIC_SHL_B: res_n = op_b << 1;
        alu_pkg::LOGIC_ROL: begin
          res_n     = rol;
          flags.err = amt_oor;  // Result kept
        end
        default: begin  // LOGIC_ROR
          res_n     = ror;
          flags.err = amt_oor;
        end
      endcase
    end
  end

  assign result = {{W{1'b0}}, res_n};

endmodule

// File: hw/alu_operand_stage.sv
`timescale 1ns/1ns

module alu_operand_stage #(
  parameter int OPERAND_WIDTH = 8
) (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          ce,
  input  logic                          mode,
  input  logic                          cin,
  input  logic [alu_pkg::CMD_WIDTH-1:0] cmd,
  input  logic [1:0]                    inp_valid,
  input  logic [OPERAND_WIDTH-1:0]      opa,
  input  logic [OPERAND_WIDTH-1:0]      opb,
  output logic [OPERAND_WIDTH-1:0]      op_a,
  output logic [OPERAND_WIDTH-1:0]      op_b,
  output alu_pkg::alu_ctrl_t            ctrl
);

  // Operand registers
  always_ff @(posedge CLK) begin
    if (ce) begin
      op_a <= opa;
      op_b <= opb;
    end else begin
      op_a <= '0;  // Idle slot
      op_b <= '0;
    end
  end

  // Control register
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ctrl <= '0;
    end else if (ce) begin
      ctrl.en    <= 1'b1;  // Marks a live operation
      ctrl.mode  <= mode;
      ctrl.cmd   <= cmd;
      ctrl.valid <= alu_pkg::alu_valid_e'(inp_valid);
      ctrl.cin   <= cin;
    end else begin
      ctrl <= '0;  // en low, merge stage outputs zeros
    end
  end

endmodule

// File: hw/alu_pkg.sv
package alu_pkg;

  localparam int CMD_WIDTH = 4;  // Command field width

  // Operand qualification code
  typedef enum logic [1:0] {
    VALID_NONE = 2'd0,
    VALID_A    = 2'd1,
    VALID_B    = 2'd2,
    VALID_BOTH = 2'd3
  } alu_valid_e;

  localparam logic [CMD_WIDTH-1:0] ARITH_ADD     = 4'd0;
  localparam logic [CMD_WIDTH-1:0] ARITH_SUB     = 4'd1;
  localparam logic [CMD_WIDTH-1:0] ARITH_ADD_CIN = 4'd2;
  localparam logic [CMD_WIDTH-1:0] ARITH_SUB_CIN = 4'd3;
  localparam logic [CMD_WIDTH-1:0] ARITH_INC_A   = 4'd4;
  localparam logic [CMD_WIDTH-1:0] ARITH_DEC_A   = 4'd5;
  localparam logic [CMD_WIDTH-1:0] ARITH_INC_B   = 4'd6;
  localparam logic [CMD_WIDTH-1:0] ARITH_DEC_B   = 4'd7;
  localparam logic [CMD_WIDTH-1:0] ARITH_CMP     = 4'd8;
  localparam logic [CMD_WIDTH-1:0] ARITH_SADD    = 4'd11;  // Codes 9 and 10 unused
  localparam logic [CMD_WIDTH-1:0] ARITH_SSUB    = 4'd12;

  localparam logic [CMD_WIDTH-1:0] LOGIC_AND     = 4'd0;
  localparam logic [CMD_WIDTH-1:0] LOGIC_NAND    = 4'd1;
  localparam logic [CMD_WIDTH-1:0] LOGIC_OR      = 4'd2;
  localparam logic [CMD_WIDTH-1:0] LOGIC_NOR     = 4'd3;
  localparam logic [CMD_WIDTH-1:0] LOGIC_XOR     = 4'd4;
  localparam logic [CMD_WIDTH-1:0] LOGIC_XNOR    = 4'd5;
  localparam logic [CMD_WIDTH-1:0] LOGIC_NOT_A   = 4'd6;
  localparam logic [CMD_WIDTH-1:0] LOGIC_NOT_B   = 4'd7;
  localparam logic [CMD_WIDTH-1:0] LOGIC_SHR_A   = 4'd8;
  localparam logic [CMD_WIDTH-1:0] LOGIC_SHL_A   = 4'd9;
  localparam logic [CMD_WIDTH-1:0] LOGIC_SHR_B   = 4'd10;
  localparam logic [CMD_WIDTH-1:0] LOGIC_SHL_B   = 4'd11;
  localparam logic [CMD_WIDTH-1:0] LOGIC_ROL     = 4'd12;
  localparam logic [CMD_WIDTH-1:0] LOGIC_ROR     = 4'd13;

  typedef struct packed {
    logic                 en;     // Slot carries an operation
    logic                 mode;   // 1 arithmetic, 0 logic
    logic [CMD_WIDTH-1:0] cmd;
    alu_valid_e           valid;
    logic                 cin;
  } alu_ctrl_t;

  typedef struct packed {
    logic cout;
    logic oflow;
    logic e;
    logic g;
    logic l;
    logic err;
  } alu_flags_t;

endpackage

// File: hw/alu_result_merge.sv
`timescale 1ns/1ns

module alu_result_merge #(
  parameter int OPERAND_WIDTH = 8
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  alu_pkg::alu_ctrl_t           ctrl,
  input  logic [2*OPERAND_WIDTH-1:0]   arith_result,
  input  alu_pkg::alu_flags_t          arith_flags,
  input  logic [2*OPERAND_WIDTH-1:0]   logic_result,
  input  alu_pkg::alu_flags_t          logic_flags,
  output logic [2*OPERAND_WIDTH-1:0]   res,
  output logic                         cout,
  output logic                         oflow,
  output logic                         e,
  output logic                         g,
  output logic                         l,
  output logic                         err
);

  logic [2*OPERAND_WIDTH-1:0] res_n;
  alu_pkg::alu_flags_t        flags_n;
  alu_pkg::alu_flags_t        flags_q;

  // Unit select, idle slot forces zeros
  always_comb begin
    if (!ctrl.en) begin
      res_n   = '0;
      flags_n = '0;
    end else if (ctrl.mode) begin
      res_n   = arith_result;
      flags_n = arith_flags;
    end else begin
      res_n   = logic_result;
      flags_n = logic_flags;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      res     <= '0;
      flags_q <= '0;
    end else begin
      res     <= res_n;    // Result and flags in the same cycle
      flags_q <= flags_n;
    end
  end

  assign cout  = flags_q.cout;
  assign oflow = flags_q.oflow;
  assign e     = flags_q.e;
  assign g     = flags_q.g;
  assign l     = flags_q.l;
  assign err   = flags_q.err;

endmodule

// File: hw/alu_top.sv
`timescale 1ns/1ns

module alu_top #(
  parameter int OPERAND_WIDTH = 8
) (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          ce,
  input  logic                          mode,
  input  logic                          cin,
  input  logic [alu_pkg::CMD_WIDTH-1:0] cmd,
  input  logic [1:0]                    inp_valid,
  input  logic [OPERAND_WIDTH-1:0]      opa,
  input  logic [OPERAND_WIDTH-1:0]      opb,
  output logic [2*OPERAND_WIDTH-1:0]    res,
  output logic                          cout,
  output logic                          oflow,
  output logic                          e,
  output logic                          g,
  output logic                          l,
  output logic                          err
);

  logic [OPERAND_WIDTH-1:0]   op_a;          // Stage 1 operands
  logic [OPERAND_WIDTH-1:0]   op_b;
  alu_pkg::alu_ctrl_t         ctrl;
  logic [2*OPERAND_WIDTH-1:0] arith_result;
  alu_pkg::alu_flags_t        arith_flags;
  logic [2*OPERAND_WIDTH-1:0] logic_result;
  alu_pkg::alu_flags_t        logic_flags;

  alu_operand_stage #(.OPERAND_WIDTH(OPERAND_WIDTH)) operand_stage_i (
    .CLK(CLK), .RST(RST), .ce(ce), .mode(mode), .cin(cin), .cmd(cmd),
    .inp_valid(inp_valid), .opa(opa), .opb(opb),
    .op_a(op_a), .op_b(op_b), .ctrl(ctrl)
  );

  // Both units evaluate every slot
  alu_arith_unit #(.OPERAND_WIDTH(OPERAND_WIDTH)) arith_unit_i (
    .op_a(op_a), .op_b(op_b), .ctrl(ctrl),
    .result(arith_result), .flags(arith_flags)
  );

  alu_logic_unit #(.OPERAND_WIDTH(OPERAND_WIDTH)) logic_unit_i (
    .op_a(op_a), .op_b(op_b), .ctrl(ctrl),
    .result(logic_result), .flags(logic_flags)
  );

  alu_result_merge #(.OPERAND_WIDTH(OPERAND_WIDTH)) result_merge_i (
    .CLK(CLK), .RST(RST), .ctrl(ctrl),
    .arith_result(arith_result), .arith_flags(arith_flags),
    .logic_result(logic_result), .logic_flags(logic_flags),
    .res(res), .cout(cout), .oflow(oflow),
    .e(e), .g(g), .l(l), .err(err)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run the simulation, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -f alu_top.f -o alu_sim \
  && ./obj_dir/alu_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
